// ==== compile.f ====
+incdir+bench
verilog/nrisc_pkg.sv
verilog/nrisc_alu.sv
verilog/reg_file.sv
verilog/unified_mem.sv
verilog/mem_arbiter.sv
verilog/fetch_unit.sv
verilog/exec_unit.sv
verilog/nrisc_top.sv
bench/nrisc_tb.sv

// ==== bench/tb_tasks.svh ====
// Bench tasks and directed tests

function automatic void emit(input logic [3:0] op, rd, rf1, rf2);
	prog.push_back({op, rd, rf1, rf2});
endfunction

function automatic void load_imm(input logic [3:0] rd, input logic [7:0] value);
	emit(nrisc_pkg::OP_LI, rd, value[7:4], value[3:0]);
endfunction

// Store reg at r3, then step r3
function automatic void store_next(input logic [3:0] src);
	emit(nrisc_pkg::OP_SW, 4'h0, 4'h3, src);
	emit(nrisc_pkg::OP_UNARY, 4'h3, 4'h3, nrisc_pkg::UN_INC);
endfunction

function automatic void alu_to_mem(input logic [3:0] op, rf1, rf2);
	emit(op, 4'h4, rf1, rf2); // Result in r4
	store_next(4'h4);
endfunction

// A taken branch skips the fall-through marker and lands on the store
function automatic void branch_case(input logic [3:0] op, input logic taken);
	logic [7:0] target;
	target = 8'(prog.size() + 4);
	load_imm(4'h6, target);
	load_imm(4'h7, MARK_TAKEN);
	emit(op, 4'h0, 4'h6, 4'h0);
	load_imm(4'h7, MARK_FALL);
	store_next(4'h7);
	expect_q.push_back(nrisc_pkg::data_t'(taken ? MARK_TAKEN : MARK_FALL));
endfunction

task automatic expect_equal(input nrisc_pkg::data_t got, exp, input string what);
	assert (got === exp) else begin
		$display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		$display("Finished with errors");
		$fatal(1, "Check failed");
	end
endtask

task automatic host_write(input nrisc_pkg::addr_t addr, input nrisc_pkg::data_t data);
	host_req.valid = 1'b1;
	host_req.write = 1'b1;
	host_req.addr  = addr;
	host_req.wdata = data;
	do @(posedge clk); while (!host_gnt);
	@(negedge clk);
	host_req = '0;
endtask

task automatic host_read(input nrisc_pkg::addr_t addr, output nrisc_pkg::data_t data);
	host_req.valid = 1'b1;
	host_req.write = 1'b0;
	host_req.addr  = addr;
	host_req.wdata = '0;
	do @(posedge clk); while (!host_gnt);
	@(negedge clk);
	host_req = '0;
	expect_equal(nrisc_pkg::data_t'(host_rvalid), 16'h1, "host_rvalid one cycle after host_gnt");
	data = host_rdata;
endtask

task automatic load_program();
	foreach (prog[i])
		host_write(nrisc_pkg::addr_t'(i), prog[i]);
endtask

// Clears registers, flags and pc, memory keeps its contents
task automatic restart_core();
	rst_n = 1'b0;
	@(negedge clk);
	rst_n = 1'b1;
	run   = 1'b1;
endtask

task automatic run_until_halt();
	restart_core();
	do @(negedge clk); while (!halted);
	run = 1'b0;
endtask

task automatic compare_results(input nrisc_pkg::addr_t base, input string what);
	nrisc_pkg::data_t got;
	foreach (expect_q[i]) begin
		host_read(base + nrisc_pkg::addr_t'(i), got);
		expect_equal(got, expect_q[i], what);
	end
endtask

task automatic halt_and_verify(input nrisc_pkg::addr_t base, input string what);
	emit(nrisc_pkg::OP_SYS, nrisc_pkg::SYS_HALT, 4'h0, 4'h0);
	load_program();
	run_until_halt();
	compare_results(base, what);
endtask

task automatic memory_access();
	nrisc_pkg::addr_t addr;
	nrisc_pkg::data_t word, got;
	repeat (8) begin
		addr = 8'($urandom);
		word = 16'($urandom);
		host_write(addr, word);
		host_read(addr, got);
		expect_equal(got, word, "host readback");
	end
endtask

task automatic arith_ops();
	nrisc_pkg::data_t a, b;
	a = 16'($urandom % 256);
	b = 16'($urandom % 256);
	prog.delete();
	expect_q = '{a + b, a - b, a + 16'h1, b - 16'h1};
	load_imm(4'h1, a[7:0]);
	load_imm(4'h2, b[7:0]);
	load_imm(4'h3, 8'h80);
	alu_to_mem(nrisc_pkg::OP_ADD, 4'h1, 4'h2);
	alu_to_mem(nrisc_pkg::OP_SUB, 4'h1, 4'h2);
	alu_to_mem(nrisc_pkg::OP_UNARY, 4'h1, nrisc_pkg::UN_INC);
	alu_to_mem(nrisc_pkg::OP_UNARY, 4'h2, nrisc_pkg::UN_DEC);
	halt_and_verify(8'h80, "arithmetic result");
	arith_prog = prog;
	arith_exp  = expect_q;
endtask

task automatic logic_ops();
	nrisc_pkg::data_t a, b;
	a = 16'($urandom % 256);
	b = 16'($urandom % 256);
	prog.delete();
	expect_q = '{a & b, a | b, a ^ b, ~a, a >> 1, a << 1};
	load_imm(4'h1, a[7:0]);
	load_imm(4'h2, b[7:0]);
	load_imm(4'h3, 8'h90);
	alu_to_mem(nrisc_pkg::OP_AND, 4'h1, 4'h2);
	alu_to_mem(nrisc_pkg::OP_OR, 4'h1, 4'h2);
	alu_to_mem(nrisc_pkg::OP_XOR, 4'h1, 4'h2);
	alu_to_mem(nrisc_pkg::OP_UNARY, 4'h1, nrisc_pkg::UN_NOT);
	alu_to_mem(nrisc_pkg::OP_SHR, 4'h1, 4'h0);
	alu_to_mem(nrisc_pkg::OP_SHL, 4'h1, 4'h0);
	halt_and_verify(8'h90, "logic or shift result");
endtask

task automatic load_copies();
	nrisc_pkg::data_t word;
	prog.delete();
	expect_q.delete();
	load_imm(4'h1, 8'ha0);
	load_imm(4'h3, 8'hb0);
	for (int i = 0; i < 4; i++) begin
		word = 16'($urandom);
		host_write(8'ha0 + 8'(i), word);
		expect_q.push_back(word);
		emit(nrisc_pkg::OP_LW, 4'h4, 4'h1, 4'h0);
		store_next(4'h4);
		emit(nrisc_pkg::OP_UNARY, 4'h1, 4'h1, nrisc_pkg::UN_INC);
	end
	halt_and_verify(8'hb0, "loaded copy");
endtask

task automatic branch_paths();
	nrisc_pkg::data_t x;
	x = 16'h0005;
	prog.delete();
	expect_q.delete();
	load_imm(4'h3, 8'hc0);
	load_imm(4'h1, x[7:0]);
	load_imm(4'h2, x[7:0]);
	emit(nrisc_pkg::OP_SUB, 4'h4, 4'h1, 4'h2);
	branch_case(nrisc_pkg::OP_JZ, (x - x) == 16'h0);
	emit(nrisc_pkg::OP_ADD, 4'h4, 4'h1, 4'h2);
	branch_case(nrisc_pkg::OP_JZ, (x + x) == 16'h0);
	emit(nrisc_pkg::OP_UNARY, 4'h4, 4'h0, nrisc_pkg::UN_DEC); // r0 is 0, so DEC borrows
	branch_case(nrisc_pkg::OP_JC, 1'b1);
	emit(nrisc_pkg::OP_AND, 4'h4, 4'h1, 4'h2);
	branch_case(nrisc_pkg::OP_JC, 1'b0); // Carry cleared by AND
	branch_case(nrisc_pkg::OP_JMP, 1'b1);
	halt_and_verify(8'hc0, "branch marker");
endtask

task automatic priority_under_load();
	nrisc_pkg::data_t got;
	int               reads;
	prog     = arith_prog;
	expect_q = arith_exp;
	load_program();
	foreach (expect_q[i])
		host_write(8'h80 + 8'(i), 16'h0); // Wipe the earlier results
	reads = 0;
	restart_core();
	while (!halted) begin
		host_read(8'(reads % prog.size()), got);
		expect_equal(got, prog[reads % prog.size()], "program word read under load");
		reads++;
		@(negedge clk); // Free slot for the core
	end
	run = 1'b0;
	compare_results(8'h80, "arithmetic result under host load");
endtask

// ==== bench/nrisc_tb.sv ====
// NRISC core testbench
`timescale 1ns/10ps
module nrisc_tb;

	localparam int         CLK_PERIOD  = 40;
	localparam int         TEST_CYCLES = 1500; // Rough sum of all six tests, host load included
	localparam logic [7:0] MARK_TAKEN  = 8'ha5;
	localparam logic [7:0] MARK_FALL   = 8'h5a;

	logic                clk;
	logic                rst_n;
	logic                run;
	nrisc_pkg::mem_req_t host_req;
	logic                host_gnt;
	nrisc_pkg::data_t    host_rdata;
	logic                host_rvalid;
	logic                halted;

	nrisc_pkg::data_t prog[$];     // Program image
	nrisc_pkg::data_t expect_q[$]; // Words the program should leave in memory
	nrisc_pkg::data_t arith_prog[$];
	nrisc_pkg::data_t arith_exp[$];

	nrisc_top dut_i (.clk, .rst_n, .run, .host_req, .host_gnt, .host_rdata, .host_rvalid,
		.halted);

	always #(CLK_PERIOD/2) clk = ~clk;

	`include "tb_tasks.svh"

	initial begin
		#(4 * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired, the tests did not complete in time");
		$display("Finished with errors");
		$fatal(1, "Simulation stopped by the watchdog");
	end

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		run      = 1'b0;
		host_req = '0;
		void'($urandom(32'hcdbd877a));
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		memory_access();
		arith_ops();
		logic_ops();
		load_copies();
		branch_paths();
		priority_under_load();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== verilog/nrisc_top.sv ====
// NRISC core top level
`timescale 1ns/10ps
module nrisc_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,
	input  nrisc_pkg::mem_req_t  host_req,
	output logic                 host_gnt,
	output nrisc_pkg::data_t     host_rdata,
	output logic                 host_rvalid,
	output logic                 halted
);

	nrisc_pkg::mem_req_t   exec_req, fetch_req, mem_req;
	logic                  exec_gnt, fetch_gnt, exec_rvalid, fetch_rvalid;
	nrisc_pkg::data_t      rdata;
	nrisc_pkg::instr_t     instr;
	logic                  instr_valid, instr_done, jump_en;
	nrisc_pkg::addr_t      jump_target;
	nrisc_pkg::reg_idx_t   rf1_idx, rf2_idx, wr_idx;
	nrisc_pkg::data_t      rf1_data, rf2_data, wr_data;
	logic                  wr_en;
	nrisc_pkg::alu_op_e    alu_op;
	nrisc_pkg::data_t      alu_a, alu_b, alu_result;
	nrisc_pkg::alu_flags_t alu_flags;

	assign host_rdata = rdata; // Shared read data

	mem_arbiter arb_i (.clk, .rst_n, .host_req, .exec_req, .fetch_req, .host_gnt, .exec_gnt,
		.fetch_gnt, .host_rvalid, .exec_rvalid, .fetch_rvalid, .mem_req);

	unified_mem mem_i (.clk, .mem_req, .rdata);

	fetch_unit fetch_i (.clk, .rst_n, .run, .halted, .fetch_req, .fetch_gnt, .fetch_rvalid,
		.rdata, .instr, .instr_pc(), .instr_valid, .instr_done, .jump_en, .jump_target);

	exec_unit exec_i (.clk, .rst_n, .run, .instr, .instr_valid, .instr_done, .jump_en,
		.jump_target, .exec_req, .exec_gnt, .exec_rvalid, .rdata, .rf1_idx, .rf2_idx,
		.rf1_data, .rf2_data, .wr_en, .wr_idx, .wr_data, .alu_op, .alu_a, .alu_b,
		.alu_result, .alu_flags, .halted);

	reg_file rf_i (.clk, .rst_n, .rf1_idx, .rf2_idx, .rf1_data, .rf2_data, .wr_en, .wr_idx,
		.wr_data);

	nrisc_alu alu_i (.alu_op, .alu_a, .alu_b, .alu_result, .alu_flags);

endmodule

// ==== verilog/exec_unit.sv ====
// Decode and execute unit
`timescale 1ns/10ps
module exec_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run,
	input  nrisc_pkg::instr_t     instr,
	input  logic                  instr_valid,
	output logic                  instr_done,
	output logic                  jump_en,
	output nrisc_pkg::addr_t      jump_target,
	output nrisc_pkg::mem_req_t   exec_req,
	input  logic                  exec_gnt,
	input  logic                  exec_rvalid,
	input  nrisc_pkg::data_t      rdata,
	output nrisc_pkg::reg_idx_t   rf1_idx,
	output nrisc_pkg::reg_idx_t   rf2_idx,
	input  nrisc_pkg::data_t      rf1_data,
	input  nrisc_pkg::data_t      rf2_data,
	output logic                  wr_en,
	output nrisc_pkg::reg_idx_t   wr_idx,
	output nrisc_pkg::data_t      wr_data,
	output nrisc_pkg::alu_op_e    alu_op,
	output nrisc_pkg::data_t      alu_a,
	output nrisc_pkg::data_t      alu_b,
	input  nrisc_pkg::data_t      alu_result,
	input  nrisc_pkg::alu_flags_t alu_flags,
	output logic                  halted
);

	nrisc_pkg::alu_flags_t flags;
	logic                  ld_wait; // LW granted, data due
	logic                  is_alu, is_lw, is_sw, is_li, is_halt, is_incdec;
	logic                  active;

	assign is_lw     = instr.opcode == nrisc_pkg::OP_LW;
	assign is_sw     = instr.opcode == nrisc_pkg::OP_SW;
	assign is_li     = instr.opcode == nrisc_pkg::OP_LI;
	assign is_halt   = instr.opcode == nrisc_pkg::OP_SYS && instr.rd == nrisc_pkg::SYS_HALT;
	assign is_incdec = instr.opcode == nrisc_pkg::OP_UNARY &&
		(instr.rf2 == nrisc_pkg::UN_INC || instr.rf2 == nrisc_pkg::UN_DEC);
	assign is_alu    = (instr.opcode >= nrisc_pkg::OP_ADD && instr.opcode <= nrisc_pkg::OP_SHL) ||
		is_incdec || (instr.opcode == nrisc_pkg::OP_UNARY && instr.rf2 == nrisc_pkg::UN_NOT);

	assign rf1_idx = instr.rf1;
	assign rf2_idx = instr.rf2;
	assign alu_a   = rf1_data;
	assign alu_b   = is_incdec ? nrisc_pkg::data_t'(1) : rf2_data;

	always_comb begin
		case (instr.opcode)
			nrisc_pkg::OP_SUB:   alu_op = nrisc_pkg::ALU_SUB;
			nrisc_pkg::OP_AND:   alu_op = nrisc_pkg::ALU_AND;
			nrisc_pkg::OP_OR:    alu_op = nrisc_pkg::ALU_OR;
			nrisc_pkg::OP_XOR:   alu_op = nrisc_pkg::ALU_XOR;
			nrisc_pkg::OP_SHR:   alu_op = nrisc_pkg::ALU_SHR;
			nrisc_pkg::OP_SHL:   alu_op = nrisc_pkg::ALU_SHL;
			nrisc_pkg::OP_UNARY: begin
				if (instr.rf2 == nrisc_pkg::UN_NOT)
					alu_op = nrisc_pkg::ALU_NOT;
				else if (instr.rf2 == nrisc_pkg::UN_DEC)
					alu_op = nrisc_pkg::ALU_SUB;
				else
					alu_op = nrisc_pkg::ALU_ADD;
			end
			default:             alu_op = nrisc_pkg::ALU_ADD;
		endcase
	end

	// Load and store address comes from rf1
	assign active          = run & instr_valid & ~halted;
	assign exec_req.valid  = active & (is_lw | is_sw) & ~ld_wait;
	assign exec_req.write  = is_sw;
	assign exec_req.addr   = rf1_data[nrisc_pkg::ADDR_W-1:0];
	assign exec_req.wdata  = rf2_data;

	always_comb begin
		if (is_sw)
			instr_done = active & exec_gnt;
		else if (is_lw)
			instr_done = active & ld_wait & exec_rvalid;
		else
			instr_done = active;
	end

	assign jump_en = instr.opcode == nrisc_pkg::OP_JMP ||
		(instr.opcode == nrisc_pkg::OP_JZ && flags.zero) ||
		(instr.opcode == nrisc_pkg::OP_JC && flags.carry);
	assign jump_target = rf1_data[nrisc_pkg::ADDR_W-1:0];

	assign wr_en   = instr_done & (is_alu | is_li | is_lw);
	assign wr_idx  = instr.rd;
	assign wr_data = is_lw ? rdata :
		is_li ? nrisc_pkg::data_t'({instr.rf1, instr.rf2}) : alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags   <= '0;
			halted  <= 1'b0;
			ld_wait <= 1'b0;
		end else begin
			if (exec_req.valid && exec_gnt && is_lw)
				ld_wait <= 1'b1;
			else if (exec_rvalid)
				ld_wait <= 1'b0;
			if (instr_done && is_alu)
				flags <= alu_flags;
			if (instr_done && is_halt)
				halted <= 1'b1; // Held until reset
		end
	end

endmodule

// ==== verilog/fetch_unit.sv ====
// Instruction fetch unit
`timescale 1ns/10ps
module fetch_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  logic                halted,
	output nrisc_pkg::mem_req_t fetch_req,
	input  logic                fetch_gnt,
	input  logic                fetch_rvalid,
	input  nrisc_pkg::data_t    rdata,
	output nrisc_pkg::instr_t   instr,
	output nrisc_pkg::addr_t    instr_pc,
	output logic                instr_valid,
	input  logic                instr_done,
	input  logic                jump_en,
	input  nrisc_pkg::addr_t    jump_target
);

	nrisc_pkg::addr_t  pc;
	nrisc_pkg::instr_t held;
	logic              held_valid;
	logic              pending; // Read in flight

	// Word is usable in its rvalid cycle, then from the holding register
	assign instr_valid = held_valid | fetch_rvalid;
	assign instr       = held_valid ? held : nrisc_pkg::instr_t'(rdata);
	assign instr_pc    = pc;

	assign fetch_req.valid = run & ~halted & ~instr_valid & ~pending;
	assign fetch_req.write = 1'b0;
	assign fetch_req.addr  = pc;
	assign fetch_req.wdata = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc         <= '0;
			held_valid <= 1'b0;
			pending    <= 1'b0;
		end else begin
			if (fetch_gnt)
				pending <= 1'b1;
			else if (fetch_rvalid)
				pending <= 1'b0;
			held_valid <= instr_valid & ~instr_done;
			if (instr_done)
				pc <= jump_en ? jump_target : pc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_rvalid)
			held <= nrisc_pkg::instr_t'(rdata);
	end

endmodule

// ==== verilog/mem_arbiter.sv ====
// Fixed priority memory arbiter
`timescale 1ns/10ps
module mem_arbiter (
	input  logic                clk,
	input  logic                rst_n,
	input  nrisc_pkg::mem_req_t host_req,
	input  nrisc_pkg::mem_req_t exec_req,
	input  nrisc_pkg::mem_req_t fetch_req,
	output logic                host_gnt,
	output logic                exec_gnt,
	output logic                fetch_gnt,
	output logic                host_rvalid,
	output logic                exec_rvalid,
	output logic                fetch_rvalid,
	output nrisc_pkg::mem_req_t mem_req
);

	logic [2:0] rd_owner; // host, exec, fetch

	// Host first, then execute, then fetch
	assign host_gnt  = host_req.valid;
	assign exec_gnt  = exec_req.valid & ~host_req.valid;
	assign fetch_gnt = fetch_req.valid & ~host_req.valid & ~exec_req.valid;

	always_comb begin
		if (host_gnt)
			mem_req = host_req;
		else if (exec_gnt)
			mem_req = exec_req;
		else if (fetch_gnt)
			mem_req = fetch_req;
		else
			mem_req = '0;
	end

	// Steer next cycle's read data to whoever issued the read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_owner <= '0;
		else
			rd_owner <= {host_gnt, exec_gnt, fetch_gnt} & {3{~mem_req.write}};
	end

	assign host_rvalid  = rd_owner[2];
	assign exec_rvalid  = rd_owner[1];
	assign fetch_rvalid = rd_owner[0];

endmodule

// ==== verilog/unified_mem.sv ====
// Unified program and data memory
`timescale 1ns/10ps
module unified_mem (
	input  logic                clk,
	input  nrisc_pkg::mem_req_t mem_req,
	output nrisc_pkg::data_t    rdata
);

	nrisc_pkg::data_t mem [nrisc_pkg::MEM_DEPTH];

	// Single port, read data registered
	always_ff @(posedge clk) begin
		if (mem_req.valid) begin
			if (mem_req.write)
				mem[mem_req.addr] <= mem_req.wdata;
			else
				rdata <= mem[mem_req.addr];
		end
	end

endmodule

// ==== verilog/reg_file.sv ====
// General purpose register file
`timescale 1ns/10ps
module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  nrisc_pkg::reg_idx_t rf1_idx,
	input  nrisc_pkg::reg_idx_t rf2_idx,
	output nrisc_pkg::data_t    rf1_data,
	output nrisc_pkg::data_t    rf2_data,
	input  logic                wr_en,
	input  nrisc_pkg::reg_idx_t wr_idx,
	input  nrisc_pkg::data_t    wr_data
);

	nrisc_pkg::data_t regs [2**nrisc_pkg::REG_IDX_W];

	assign rf1_data = regs[rf1_idx];
	assign rf2_data = regs[rf2_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**nrisc_pkg::REG_IDX_W; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

// ==== verilog/nrisc_alu.sv ====
// Combinational ALU
`timescale 1ns/10ps
module nrisc_alu (
	input  nrisc_pkg::alu_op_e    alu_op,
	input  nrisc_pkg::data_t      alu_a,
	input  nrisc_pkg::data_t      alu_b,
	output nrisc_pkg::data_t      alu_result,
	output nrisc_pkg::alu_flags_t alu_flags
);

	logic [nrisc_pkg::DATA_W:0] wide; // Extra bit is carry or borrow

	always_comb begin
		wide = '0;
		case (alu_op)
			nrisc_pkg::ALU_ADD: wide = {1'b0, alu_a} + {1'b0, alu_b};
			nrisc_pkg::ALU_SUB: wide = {1'b0, alu_a} - {1'b0, alu_b};
			nrisc_pkg::ALU_AND: wide = {1'b0, alu_a & alu_b};
			nrisc_pkg::ALU_OR:  wide = {1'b0, alu_a | alu_b};
			nrisc_pkg::ALU_XOR: wide = {1'b0, alu_a ^ alu_b};
			nrisc_pkg::ALU_SHR: wide = {alu_a[0], 1'b0, alu_a[nrisc_pkg::DATA_W-1:1]};
			nrisc_pkg::ALU_SHL: wide = {alu_a, 1'b0}; // MSB falls into carry
			nrisc_pkg::ALU_NOT: wide = {1'b0, ~alu_a};
			default:            wide = '0;
		endcase
	end

	assign alu_result      = wide[nrisc_pkg::DATA_W-1:0];
	assign alu_flags.carry = wide[nrisc_pkg::DATA_W];
	assign alu_flags.zero  = alu_result == '0;

endmodule

// ==== verilog/nrisc_pkg.sv ====
// NRISC shared definitions
package nrisc_pkg;

	localparam int DATA_W    = 16;
	localparam int ADDR_W    = 8;
	localparam int MEM_DEPTH = 256;
	localparam int REG_IDX_W = 4;

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Instruction word, opcode in the top nibble
	typedef struct packed {
		logic [3:0] opcode;
		reg_idx_t   rd;
		reg_idx_t   rf1;
		reg_idx_t   rf2;
	} instr_t;

	localparam logic [3:0] OP_SYS   = 4'h0;
	localparam logic [3:0] OP_LW    = 4'h1;
	localparam logic [3:0] OP_SW    = 4'h2;
	localparam logic [3:0] OP_LI    = 4'h3;
	localparam logic [3:0] OP_JMP   = 4'h4;
	localparam logic [3:0] OP_JZ    = 4'h5;
	localparam logic [3:0] OP_JC    = 4'h6;
	localparam logic [3:0] OP_ADD   = 4'h8;
	localparam logic [3:0] OP_SUB   = 4'h9;
	localparam logic [3:0] OP_AND   = 4'ha;
	localparam logic [3:0] OP_OR    = 4'hb;
	localparam logic [3:0] OP_XOR   = 4'hc;
	localparam logic [3:0] OP_SHR   = 4'hd;
	localparam logic [3:0] OP_SHL   = 4'he;
	localparam logic [3:0] OP_UNARY = 4'hf;

	localparam logic [3:0] SYS_HALT = 4'h1; // rd field
	localparam logic [3:0] UN_NOT   = 4'h0; // rf2 field
	localparam logic [3:0] UN_INC   = 4'h2;
	localparam logic [3:0] UN_DEC   = 4'h3;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHR, ALU_SHL, ALU_NOT
	} alu_op_e;

	typedef struct packed {
		logic zero;
		logic carry;
	} alu_flags_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

endpackage
